// File: src/eeprom_pkg.sv
package eeprom_pkg;

  // memory geometry of the 2 KB device
  localparam int addr_w    = 11;
  localparam int blk_w     = addr_w - 8;  // address bits carried in the control byte
  localparam int mem_bytes = 1 << addr_w;

  // device type code, upper nibble of every control byte
  localparam logic [3:0] dev_code_c = 4'b1010;

  // operations of the bit engine
  typedef enum logic [1:0] {
    cmd_start = 2'd0,  // repeated start if the bus is still held
    cmd_stop  = 2'd1,
    cmd_write = 2'd2,  // byte out, then sample ack
    cmd_read  = 2'd3   // byte in, then drive ack_out
  } bus_cmd_e;

  // Control byte as it goes over the wire.
  // raw is the view used while shifting; f is the view used to build and decode it.
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [3:0]       dev_code;
      logic [blk_w-1:0] block;  // addr[10:8]
      logic             rw;     // 1 = read
    } f;
  } ctrl_byte_u;

endpackage

// File: src/i2c_cmd_if.sv
`timescale 1ns/1ps

interface i2c_cmd_if import eeprom_pkg::*; ();

  // sequencer to engine
  logic       cmd_valid;
  bus_cmd_e   cmd;
  logic [7:0] tx_byte;
  logic       ack_out;    // bit sent after a read byte, 1 = nack

  // engine to sequencer
  logic       cmd_ready;  // engine idle between primitives
  logic       done;       // one cycle at end of a primitive
  logic [7:0] rx_byte;
  logic       ack_in;     // sampled ack, 1 = nack

  modport seq (
    output cmd_valid, cmd, tx_byte, ack_out,
    input  cmd_ready, done, rx_byte, ack_in
  );

  modport engine (
    input  cmd_valid, cmd, tx_byte, ack_out,
    output cmd_ready, done, rx_byte, ack_in
  );

endinterface

// File: src/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine import eeprom_pkg::*; #(
  parameter int clk_div = 4  // clk cycles per quarter scl period
) (
  input  logic      clk,
  input  logic      reset,
  i2c_cmd_if.engine cmd_port,
  output logic      scl,
  output logic      sda_pull_low,
  input  logic      sda_in
);

  localparam int div_w = $clog2(clk_div);
  localparam logic [div_w-1:0] div_last = div_w'(clk_div - 1);

  logic             busy;
  logic             held;      // bus owned between start and stop
  bus_cmd_e         op;
  bus_cmd_e         op_sel;
  logic [div_w-1:0] div_q;
  logic [1:0]       q;         // quarter within the bit
  logic [1:0]       q_nxt;
  logic [3:0]       bit_q;     // 0..7 data, 8 ack
  logic [3:0]       bit_nxt;
  logic [7:0]       sh;        // shift out msb first, shift in at lsb
  logic             ack_q;
  logic             done_q;
  logic             ack_in_q;
  logic             accept;
  logic             quarter_end;
  logic             last_quarter;
  logic             byte_op;
  logic             tx_bit;
  logic             scl_nxt;
  logic             pull_nxt;

  assign cmd_port.cmd_ready = !busy;
  assign cmd_port.done      = done_q;
  assign cmd_port.rx_byte   = sh;
  assign cmd_port.ack_in    = ack_in_q;

  assign accept       = cmd_port.cmd_valid && !busy;
  assign quarter_end  = busy && (div_q == div_last);
  assign byte_op      = (op == cmd_write) || (op == cmd_read);
  assign last_quarter = (q == 2'd3) && (!byte_op || bit_q == 4'd8);

  // position of the quarter about to begin
  // on acceptance the incoming command is not latched yet
  assign op_sel  = busy ? op : cmd_port.cmd;
  assign q_nxt   = busy ? q + 2'd1 : 2'd0;
  assign bit_nxt = !busy ? 4'd0 : (q == 2'd3) ? bit_q + 4'd1 : bit_q;
  assign tx_bit  = busy ? sh[7] : cmd_port.tx_byte[7];

  // line levels for the quarter about to begin
  always_comb begin
    scl_nxt  = scl;
    pull_nxt = sda_pull_low;
    case (op_sel)
      cmd_start: begin
        case (q_nxt)
          2'd0: begin
            scl_nxt  = !held;  // a held bus has scl low here
            pull_nxt = 1'b0;
          end
          2'd1: scl_nxt = 1'b1;
          2'd2: pull_nxt = 1'b1;  // sda falls with scl high
          default: scl_nxt = 1'b0;
        endcase
      end
      cmd_stop: begin
        case (q_nxt)
          2'd0: pull_nxt = 1'b1;
          2'd1: scl_nxt = 1'b1;
          2'd2: pull_nxt = 1'b0;  // sda rises with scl high
          default: scl_nxt = 1'b1;
        endcase
      end
      default: begin
        case (q_nxt)
          2'd0: begin
            scl_nxt = 1'b0;
            if (bit_nxt == 4'd8) begin
              pull_nxt = (op_sel == cmd_read) ? !ack_q : 1'b0;
            end else begin
              pull_nxt = (op_sel == cmd_write) ? !tx_bit : 1'b0;
            end
          end
          2'd1: scl_nxt = 1'b1;
          2'd2: scl_nxt = 1'b1;
          default: scl_nxt = 1'b0;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy         <= 1'b0;
      held         <= 1'b0;
      op           <= cmd_start;
      div_q        <= '0;
      q            <= 2'd0;
      bit_q        <= 4'd0;
      scl          <= 1'b1;  // bus released
      sda_pull_low <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (accept || (quarter_end && !last_quarter)) begin
        scl          <= scl_nxt;
        sda_pull_low <= pull_nxt;
        q            <= q_nxt;
        bit_q        <= bit_nxt;
      end
      if (accept) begin
        busy  <= 1'b1;
        op    <= cmd_port.cmd;
        div_q <= '0;
      end else if (busy) begin
        div_q <= quarter_end ? '0 : div_q + div_w'(1);
        if (quarter_end && last_quarter) begin
          busy   <= 1'b0;
          done_q <= 1'b1;
          if (op == cmd_start) begin
            held <= 1'b1;
          end else if (op == cmd_stop) begin
            held <= 1'b0;
          end
        end
      end
    end
  end

  // data path, sampled in the middle of scl high
  always_ff @(posedge clk) begin
    if (accept) begin
      sh    <= cmd_port.tx_byte;
      ack_q <= cmd_port.ack_out;
    end else if (quarter_end && byte_op && q == 2'd1) begin
      if (bit_q != 4'd8) begin
        sh <= {sh[6:0], sda_in};
      end else if (op == cmd_write) begin
        ack_in_q <= sda_in;  // high means no device answered
      end
    end
  end

endmodule

// File: src/eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl import eeprom_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_valid,
  output logic              req_ready,
  input  logic              req_write,
  input  logic [addr_w-1:0] req_addr,
  input  logic [7:0]        req_wdata,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [7:0]        rsp_rdata,
  output logic              rsp_nack,
  i2c_cmd_if.seq            cmd_port
);

  // one-hot main states
  localparam logic [9:0] st_idle    = 10'b00_0000_0001;
  localparam logic [9:0] st_wstart  = 10'b00_0000_0010;
  localparam logic [9:0] st_ctrl_w  = 10'b00_0000_0100;
  localparam logic [9:0] st_addr_w  = 10'b00_0000_1000;
  localparam logic [9:0] st_data_w  = 10'b00_0001_0000;
  localparam logic [9:0] st_rstart  = 10'b00_0010_0000;
  localparam logic [9:0] st_ctrl_r  = 10'b00_0100_0000;
  localparam logic [9:0] st_data_r  = 10'b00_1000_0000;
  localparam logic [9:0] st_stop    = 10'b01_0000_0000;
  localparam logic [9:0] st_resp    = 10'b10_0000_0000;

  logic [9:0]        state;
  logic              issued;     // command taken by the engine, waiting for done
  logic              cmd_state;
  logic              byte_sent;  // state ends in a byte write with ack check
  logic              write_q;
  logic [addr_w-1:0] addr_q;
  logic [7:0]        wdata_q;
  logic [7:0]        rdata_q;
  logic              nack_q;
  ctrl_byte_u        ctrl_b;

  assign req_ready = (state == st_idle);
  assign rsp_valid = (state == st_resp);
  assign rsp_rdata = rdata_q;
  assign rsp_nack  = nack_q;

  assign byte_sent          = state inside {st_ctrl_w, st_addr_w, st_data_w, st_ctrl_r};
  assign cmd_port.cmd_valid = cmd_state && !issued;
  assign cmd_port.ack_out   = 1'b1;  // single byte read, always ends in nack

  always_comb begin
    ctrl_b.f.dev_code = dev_code_c;
    ctrl_b.f.block    = addr_q[addr_w-1:8];
    ctrl_b.f.rw       = (state == st_ctrl_r);
  end

  // one engine command per state
  always_comb begin
    cmd_state        = 1'b1;
    cmd_port.cmd     = cmd_write;
    cmd_port.tx_byte = ctrl_b.raw;
    case (state)
      st_wstart, st_rstart: cmd_port.cmd = cmd_start;
      st_addr_w: cmd_port.tx_byte = addr_q[7:0];
      st_data_w: cmd_port.tx_byte = wdata_q;
      st_data_r: cmd_port.cmd = cmd_read;
      st_stop: cmd_port.cmd = cmd_stop;
      st_ctrl_w, st_ctrl_r: cmd_port.tx_byte = ctrl_b.raw;
      default: cmd_state = 1'b0;  // idle, respond
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_idle;
      issued <= 1'b0;
    end else begin
      if (cmd_port.cmd_valid && cmd_port.cmd_ready) begin
        issued <= 1'b1;
      end else if (cmd_port.done) begin
        issued <= 1'b0;
      end
      case (state)
        st_idle: if (req_valid) state <= st_wstart;
        st_wstart: if (cmd_port.done) state <= st_ctrl_w;
        st_ctrl_w: if (cmd_port.done) state <= cmd_port.ack_in ? st_stop : st_addr_w;
        st_addr_w: begin
          if (cmd_port.done) begin
            if (cmd_port.ack_in) begin
              state <= st_stop;
            end else begin
              state <= write_q ? st_data_w : st_rstart;  // random read goes on
            end
          end
        end
        st_data_w: if (cmd_port.done) state <= st_stop;
        st_rstart: if (cmd_port.done) state <= st_ctrl_r;
        st_ctrl_r: if (cmd_port.done) state <= cmd_port.ack_in ? st_stop : st_data_r;
        st_data_r: if (cmd_port.done) state <= st_stop;
        st_stop: if (cmd_port.done) state <= st_resp;
        st_resp: if (rsp_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // request latch and response data
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      write_q <= req_write;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
      rdata_q <= 8'h00;
      nack_q  <= 1'b0;
    end else if (cmd_port.done) begin
      if (byte_sent && cmd_port.ack_in) nack_q <= 1'b1;
      if (state == st_data_r) rdata_q <= cmd_port.rx_byte;
    end
  end

endmodule

// File: src/eeprom_rw_top.sv
`timescale 1ns/1ps

module eeprom_rw_top import eeprom_pkg::*; #(
  parameter int clk_div = 4
) (
  input  logic              clk,
  input  logic              reset,
  // host request
  input  logic              req_valid,
  output logic              req_ready,
  input  logic              req_write,
  input  logic [addr_w-1:0] req_addr,
  input  logic [7:0]        req_wdata,
  // host response
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [7:0]        rsp_rdata,
  output logic              rsp_nack,
  // two-wire bus, open drain
  output logic              scl,
  output logic              sda_pull_low,
  input  logic              sda_in
);

  i2c_cmd_if cmd_bus ();

  eeprom_ctrl ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .rsp_nack  (rsp_nack),
    .cmd_port  (cmd_bus.seq)
  );

  i2c_bit_engine #(
    .clk_div (clk_div)
  ) engine_i (
    .clk          (clk),
    .reset        (reset),
    .cmd_port     (cmd_bus.engine),
    .scl          (scl),
    .sda_pull_low (sda_pull_low),
    .sda_in       (sda_in)
  );

endmodule

// File: verification/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model import eeprom_pkg::*; (
  input  logic clk,
  input  logic scl,
  input  logic sda,
  input  logic nack_en,   // refuse every byte
  output logic pull_low
);

  logic [7:0]        mem [mem_bytes];
  logic              scl_d    = 1'b1;
  logic              sda_d    = 1'b1;
  logic              active   = 1'b0;
  logic              sending  = 1'b0;  // device drives read data
  logic              acked    = 1'b0;
  logic              reading  = 1'b0;
  logic              pull_q   = 1'b0;
  logic [3:0]        bit_cnt  = 4'd0;  // rising scl edges in the frame
  logic [1:0]        byte_idx = 2'd0;
  logic [7:0]        shift    = 8'h00;
  logic [blk_w-1:0]  block    = '0;
  logic [addr_w-1:0] ptr      = '0;
  ctrl_byte_u        cb;
  logic              take;

  assign pull_low = pull_q;
  assign cb.raw   = shift;
  assign take     = !nack_en && (byte_idx != 2'd0 || cb.f.dev_code == dev_code_c);

  initial begin
    for (int i = 0; i < mem_bytes; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
    end
  end

  // bus oversampled on clk
  always @(posedge clk) begin
    scl_d <= scl;
    sda_d <= sda;
    if (scl && scl_d && sda_d && !sda) begin  // start or repeated start
      active   <= 1'b1;
      sending  <= 1'b0;
      bit_cnt  <= 4'd0;
      byte_idx <= 2'd0;
      pull_q   <= 1'b0;
    end else if (scl && scl_d && !sda_d && sda) begin  // stop
      active  <= 1'b0;
      sending <= 1'b0;
      pull_q  <= 1'b0;
    end else if (active && scl && !scl_d) begin
      if (bit_cnt < 4'd8 && !sending) shift <= {shift[6:0], sda};
      bit_cnt <= bit_cnt + 4'd1;
    end else if (active && !scl && scl_d) begin
      if (bit_cnt == 4'd8) begin
        if (sending) begin
          pull_q <= 1'b0;  // master answers this one
        end else begin
          acked  <= take;
          pull_q <= take;
          if (take) begin
            case (byte_idx)
              2'd0: begin
                block   <= cb.f.block;
                reading <= cb.f.rw;
              end
              2'd1: ptr <= {block, shift};
              default: mem[ptr] = shift;
            endcase
            if (byte_idx != 2'd3) byte_idx <= byte_idx + 2'd1;
          end
        end
      end else if (bit_cnt == 4'd9) begin
        bit_cnt <= 4'd0;
        pull_q  <= 1'b0;
        if (sending || !acked) begin
          active  <= 1'b0;
          sending <= 1'b0;
        end else if (reading) begin
          sending <= 1'b1;
          shift   <= mem[ptr];
          pull_q  <= !mem[ptr][7];
        end
      end else if (sending && bit_cnt != 4'd0) begin
        pull_q <= !shift[3'd7 - bit_cnt[2:0]];
      end
    end
  end

endmodule

// File: verification/eeprom_rw_assert.sv
`timescale 1ns/1ps

module eeprom_rw_assert import eeprom_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       req_ready,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input logic [7:0] rsp_rdata,
  input logic       rsp_nack,
  input logic       scl,
  input logic       sda_pull_low,
  input logic [1:0] eng_op
);

  // once a request is taken, ready stays low through the response
  a_no_req_while_rsp: assert property (@(posedge clk) disable iff (reset)
    !req_ready && !(rsp_valid && rsp_ready) |=> !req_ready)
    else $error("req_ready rose before the response was consumed");

  a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_nack))
    else $error("response changed while rsp_ready was low");

  // sda only moves under a high scl for start and stop
  a_sda_scl_high: assert property (@(posedge clk) disable iff (reset)
    scl && $past(scl) && (sda_pull_low != $past(sda_pull_low))
      |-> (eng_op == cmd_start || eng_op == cmd_stop))
    else $error("sda_pull_low changed with scl high outside start or stop");

endmodule

bind eeprom_rw_top eeprom_rw_assert assert_i (
  .clk          (clk),
  .reset        (reset),
  .req_ready    (req_ready),
  .rsp_valid    (rsp_valid),
  .rsp_ready    (rsp_ready),
  .rsp_rdata    (rsp_rdata),
  .rsp_nack     (rsp_nack),
  .scl          (scl),
  .sda_pull_low (sda_pull_low),
  .eng_op       (engine_i.op)
);

// File: verification/eeprom_rw_tb.sv
`timescale 1ns/1ps

module eeprom_rw_tb import eeprom_pkg::*; ();

  localparam int clk_div   = 4;
  localparam int rd_cycles = 156 * clk_div;  // three edges and four bytes

  logic              clk        = 1'b0;
  logic              reset      = 1'b1;
  logic              req_valid  = 1'b0;
  logic              req_write  = 1'b0;
  logic [addr_w-1:0] req_addr   = '0;
  logic [7:0]        req_wdata  = 8'h00;
  logic              rsp_ready  = 1'b0;
  logic              model_nack = 1'b0;
  logic              req_ready;
  logic              rsp_valid;
  logic [7:0]        rsp_rdata;
  logic              rsp_nack;
  logic              scl;
  logic              sda_pull_low;
  logic              model_pull;
  wire               sda = !(sda_pull_low || model_pull);  // wired-and

  string             tbl_name[$];
  logic              tbl_write[$];
  logic [addr_w-1:0] tbl_addr[$];
  logic [7:0]        tbl_data[$];
  logic              tbl_nack[$];
  int                tbl_hold[$];
  logic [7:0]        ref_mem[mem_bytes];
  logic [31:0]       lfsr        = 32'hffc3;
  logic              table_built = 1'b0;
  int                checks      = 0;
  int                errors      = 0;
  int                passed      = 0;
  int                failed      = 0;

  always #10 clk = !clk;

  eeprom_rw_top #(.clk_div(clk_div)) dut_i (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
    .req_addr(req_addr), .req_wdata(req_wdata),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
    .rsp_nack(rsp_nack),
    .scl(scl), .sda_pull_low(sda_pull_low), .sda_in(sda)
  );

  eeprom_model model_i (
    .clk(clk), .scl(scl), .sda(sda), .nack_en(model_nack), .pull_low(model_pull)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_entry(input string name, input logic wr, input logic [addr_w-1:0] addr,
                           input logic [7:0] data, input logic nack, input int hold);
    tbl_name.push_back(name);
    tbl_write.push_back(wr);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_nack.push_back(nack);
    tbl_hold.push_back(hold);
  endtask

  task automatic check(input string test, input string what,
                       input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, expected, actual);
    end
  endtask

  task automatic report_test(input string test, input int err_before);
    if (errors == err_before) passed++;
    else failed++;
    $display("%s %s", (errors == err_before) ? "PASS" : "FAIL", test);
  endtask

  task automatic bus_idle_check(input string test);
    check(test, "scl", 32'd1, 32'(scl));
    check(test, "sda_pull_low", 32'd0, 32'(sda_pull_low));
    check(test, "req_ready", 32'd1, 32'(req_ready));
    check(test, "rsp_valid", 32'd0, 32'(rsp_valid));
  endtask

  task automatic run_entry(input int i);
    logic [7:0] exp_data;
    logic [7:0] got_data;
    logic       got_nack;
    int         err_before;
    err_before = errors;
    exp_data   = (!tbl_write[i] && !tbl_nack[i]) ? ref_mem[tbl_addr[i]] : 8'h00;
    @(posedge clk);
    model_nack <= tbl_nack[i];
    req_valid  <= 1'b1;
    req_write  <= tbl_write[i];
    req_addr   <= tbl_addr[i];
    req_wdata  <= tbl_data[i];
    rsp_ready  <= (tbl_hold[i] == 0);
    do @(posedge clk); while (!req_ready);
    req_valid <= (tbl_hold[i] != 0);  // keeps knocking under back-pressure
    do @(posedge clk); while (!rsp_valid);
    got_data = rsp_rdata;
    got_nack = rsp_nack;
    for (int c = 0; c < tbl_hold[i]; c++) begin
      @(posedge clk);
      check(tbl_name[i], "held rsp_valid", 32'd1, 32'(rsp_valid));
      check(tbl_name[i], "held rsp_rdata", 32'(exp_data), 32'(rsp_rdata));
      check(tbl_name[i], "held rsp_nack", 32'(tbl_nack[i]), 32'(rsp_nack));
      check(tbl_name[i], "held req_ready", 32'd0, 32'(req_ready));
    end
    if (tbl_hold[i] != 0) begin
      rsp_ready <= 1'b1;
      req_valid <= 1'b0;
      @(posedge clk);
    end
    @(posedge clk);
    check(tbl_name[i], "rsp_rdata", 32'(exp_data), 32'(got_data));
    check(tbl_name[i], "rsp_nack", 32'(tbl_nack[i]), 32'(got_nack));
    bus_idle_check(tbl_name[i]);
    if (tbl_write[i] && !tbl_nack[i]) ref_mem[tbl_addr[i]] = tbl_data[i];
    report_test(tbl_name[i], err_before);
  endtask

  initial begin
    logic [31:0]       rnd;
    logic [addr_w-1:0] ra;
    for (int i = 0; i < mem_bytes; i++) begin
      ref_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;  // erased content of the device
    end
    take_bits(8, rnd);
    add_entry("write_basic", 1'b1, 11'h123, rnd[7:0], 1'b0, 0);
    add_entry("read_basic", 1'b0, 11'h123, 8'h00, 1'b0, 0);
    take_bits(8, rnd);
    add_entry("write_blk0", 1'b1, 11'h045, rnd[7:0], 1'b0, 0);
    take_bits(8, rnd);
    add_entry("write_blk5", 1'b1, 11'h545, rnd[7:0], 1'b0, 0);
    take_bits(8, rnd);
    add_entry("write_blk7", 1'b1, 11'h745, rnd[7:0], 1'b0, 0);
    add_entry("read_blk0", 1'b0, 11'h045, 8'h00, 1'b0, 0);
    add_entry("read_blk5", 1'b0, 11'h545, 8'h00, 1'b0, 0);
    add_entry("read_blk7", 1'b0, 11'h745, 8'h00, 1'b0, 0);
    take_bits(8, rnd);
    add_entry("overwrite", 1'b1, 11'h123, rnd[7:0], 1'b0, 0);
    add_entry("read_overwrite", 1'b0, 11'h123, 8'h00, 1'b0, 0);
    add_entry("read_blk5_again", 1'b0, 11'h545, 8'h00, 1'b0, 0);
    add_entry("write_nack", 1'b1, 11'h200, 8'h3c, 1'b1, 0);
    add_entry("read_nack", 1'b0, 11'h045, 8'h00, 1'b1, 0);
    add_entry("read_after_nack", 1'b0, 11'h200, 8'h00, 1'b0, 0);
    take_bits(11, rnd);
    ra = rnd[10:0];
    take_bits(8, rnd);
    add_entry("write_random", 1'b1, ra, rnd[7:0], 1'b0, 0);
    add_entry("read_random", 1'b0, ra, 8'h00, 1'b0, 0);
    add_entry("read_held", 1'b0, 11'h045, 8'h00, 1'b0, 7);
    take_bits(8, rnd);
    add_entry("write_held", 1'b1, 11'h7ff, rnd[7:0], 1'b0, 5);
    add_entry("read_held_top", 1'b0, 11'h7ff, 8'h00, 1'b0, 3);
    table_built = 1'b1;

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    bus_idle_check("reset");
    report_test("reset", 0);
    for (int i = 0; i < tbl_name.size(); i++) begin
      run_entry(i);
    end
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             passed + failed, passed, failed, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    int limit;
    wait (table_built);
    limit = tbl_name.size() * (rd_cycles + 40) + 200;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: list.f
src/eeprom_pkg.sv
src/i2c_cmd_if.sv
src/i2c_bit_engine.sv
src/eeprom_ctrl.sv
src/eeprom_rw_top.sv
verification/eeprom_model.sv
verification/eeprom_rw_assert.sv
verification/eeprom_rw_tb.sv

// File: run.sh
#!/bin/sh
# a failed build or a crashed run also counts as a failure
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module eeprom_rw_tb \
  -f list.f -o eeprom_rw_sim > build.log 2>&1 &&
  ./obj_dir/eeprom_rw_sim > sim.log 2>&1 ||
  echo "Finished with errors" >> sim.log
cat sim.log
! grep -q "Finished with errors" sim.log
